// ==== common/corePkg.sv ====
// Shared opcode, ALU operation, immediate and result source types, imported by every pipeline block
`default_nettype none

package corePkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int RegAddrWidth = 5;   // x0..x31
  localparam int DefaultXlen  = 32;  // Only value the RV32I subset supports

  //////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////

  // Bits [6:0] of the instruction word
  typedef enum logic [6:0] {
    opReg   = 7'b0110011,  // Register-register ALU
    opImm   = 7'b0010011,  // Register-immediate ALU
    opLui   = 7'b0110111,  // Load upper immediate
    opLoad  = 7'b0000011,  // lw only
    opStore = 7'b0100011   // sw only
  } opcodeT;

  //////////////////////////////////////////////////
  // ALU operations
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluSub  = 4'd1,
    aluAnd  = 4'd2,
    aluOr   = 4'd3,
    aluXor  = 4'd4,
    aluSlt  = 4'd5,   // Signed compare
    aluSltu = 4'd6,   // Unsigned compare
    aluSll  = 4'd7,
    aluSrl  = 4'd8,
    aluSra  = 4'd9    // Keeps the sign bit
  } aluOpT;

  // Immediate layouts seen in Decode
  typedef enum logic [1:0] {
    immI = 2'd0,  // ALU immediates and lw offset
    immS = 2'd1,  // sw offset split over two fields
    immU = 2'd2   // lui upper 20 bits
  } immSrcT;

  // Writeback source
  typedef enum logic {
    resAlu = 1'b0,  // ALU or lui result
    resMem = 1'b1   // Load data from memory
  } resultSrcT;

endpackage

`default_nettype wire

// ==== datapath/regFile.sv ====
// Integer register file with two read ports, one write port and same-cycle bypass for the datapath
`timescale 1ns/10ps
`default_nettype none

module regFile #(
  parameter int XLEN = corePkg::DefaultXlen
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             WriteEn,
  input  logic [corePkg::RegAddrWidth-1:0] Ra1,
  input  logic [corePkg::RegAddrWidth-1:0] Ra2,
  input  logic [corePkg::RegAddrWidth-1:0] Wa,
  input  logic [XLEN-1:0]                  Wd,
  output logic [XLEN-1:0]                  Rd1,
  output logic [XLEN-1:0]                  Rd2
);

  import corePkg::*;

  logic [XLEN-1:0] Regs [2**RegAddrWidth];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**RegAddrWidth; i++) Regs[i] <= '0;
    end else if (WriteEn && Wa != '0) begin  // x0 never written
      Regs[Wa] <= Wd;
    end
  end

  // Write-through so Decode sees the Writeback value
  assign Rd1 = (Ra1 == '0) ? '0 : (WriteEn && Wa == Ra1) ? Wd : Regs[Ra1];
  assign Rd2 = (Ra2 == '0) ? '0 : (WriteEn && Wa == Ra2) ? Wd : Regs[Ra2];

endmodule

`default_nettype wire

// ==== datapath/alu.sv ====
// Integer ALU for the Execute stage with add/sub, logic, compares and shifts
`timescale 1ns/10ps
`default_nettype none

module alu #(
  parameter int XLEN = corePkg::DefaultXlen
) (
  input  logic [XLEN-1:0] SrcA,
  input  logic [XLEN-1:0] SrcB,
  input  corePkg::aluOpT  AluOp,
  output logic [XLEN-1:0] Result
);

  import corePkg::*;

  logic            Sub;          // Invert B and carry in
  logic [XLEN-1:0] SrcBInv;
  logic [XLEN-1:0] Sum;
  logic            CarryOut;
  logic            Lt, Ltu;
  logic [4:0]      Shamt;

  //////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////

  // Compares subtract too
  assign Sub     = (AluOp == aluSub) || (AluOp == aluSlt) || (AluOp == aluSltu);
  assign SrcBInv = Sub ? ~SrcB : SrcB;
  assign {CarryOut, Sum} = {1'b0, SrcA} + {1'b0, SrcBInv} + {{XLEN{1'b0}}, Sub};

  // Signs differ so A is less exactly when A is negative
  assign Lt  = (SrcA[XLEN-1] != SrcB[XLEN-1]) ? SrcA[XLEN-1] : Sum[XLEN-1];
  assign Ltu = ~CarryOut;       // Borrow out of A - B

  assign Shamt = SrcB[4:0];

  always_comb begin
    case (AluOp)
      aluAdd,
      aluSub:  Result = Sum;
      aluAnd:  Result = SrcA & SrcB;
      aluOr:   Result = SrcA | SrcB;
      aluXor:  Result = SrcA ^ SrcB;
      aluSlt:  Result = XLEN'(Lt);
      aluSltu: Result = XLEN'(Ltu);
      aluSll:  Result = SrcA << Shamt;
      aluSrl:  Result = SrcA >> Shamt;
      aluSra:  Result = $unsigned($signed(SrcA) >>> Shamt);  // Sign fill
      default: Result = Sum;
    endcase
  end

endmodule

`default_nettype wire

// ==== datapath/datapath.sv ====
// Integer datapath with operand read, forwarding, ALU and the Execute/Memory/Writeback registers
`timescale 1ns/10ps
`default_nettype none

module datapath #(
  parameter int XLEN = corePkg::DefaultXlen
) (
  input  logic                            clk,
  input  logic                            reset,
  // Decode
  input  logic [31:0]                     InstrD,
  input  logic                            StallD,     // Hold Decode
  input  logic                            FlushE,     // Bubble into Execute
  input  corePkg::immSrcT                 ImmSrcD,
  // Execute
  input  corePkg::aluOpT                  AluOpE,
  input  logic                            AluSrcBE,   // Immediate as second operand
  input  logic                            LuiE,       // Pass immediate as result
  input  logic [1:0]                      ForwardAE,
  input  logic [1:0]                      ForwardBE,
  // Writeback
  input  logic                            RegWriteW,
  input  corePkg::resultSrcT              ResultSrcW,
  input  logic [XLEN-1:0]                 ReadDataW,
  // Register numbers to hazard unit
  output logic [corePkg::RegAddrWidth-1:0] Rs1D,
  output logic [corePkg::RegAddrWidth-1:0] Rs2D,
  output logic [corePkg::RegAddrWidth-1:0] Rs1E,
  output logic [corePkg::RegAddrWidth-1:0] Rs2E,
  output logic [corePkg::RegAddrWidth-1:0] RdE,
  output logic [corePkg::RegAddrWidth-1:0] RdM,
  output logic [corePkg::RegAddrWidth-1:0] RdW,
  // Memory port and writeback value
  output logic [XLEN-1:0]                 MemAdrM,
  output logic [XLEN-1:0]                 WriteDataM,
  output logic [XLEN-1:0]                 ResultW
);

  import corePkg::*;

  logic [RegAddrWidth-1:0] RdD;
  logic [XLEN-1:0]         R1D, R2D;          // Register file reads
  logic [XLEN-1:0]         ImmExtD;
  logic [XLEN-1:0]         R1E, R2E, ImmExtE;
  logic [XLEN-1:0]         SrcAE, SrcBE;
  logic [XLEN-1:0]         WriteDataE;        // Forwarded rs2, store data
  logic [XLEN-1:0]         AluResultE, IeuResultE;
  logic [XLEN-1:0]         IeuResultM, IeuResultW;

  // Operand select, 10 from Memory, 01 from Writeback
  function automatic logic [XLEN-1:0] fwdMux(input logic [1:0] Sel, input logic [XLEN-1:0] RegVal,
                                             input logic [XLEN-1:0] MemVal,
                                             input logic [XLEN-1:0] WbVal);
    case (Sel)
      2'b10:   return MemVal;
      2'b01:   return WbVal;
      default: return RegVal;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign Rs1D = InstrD[19:15];
  assign Rs2D = InstrD[24:20];
  assign RdD  = InstrD[11:7];

  regFile #(.XLEN(XLEN)) rf (
    .clk(clk), .reset(reset), .WriteEn(RegWriteW),
    .Ra1(Rs1D), .Ra2(Rs2D), .Wa(RdW), .Wd(ResultW),
    .Rd1(R1D), .Rd2(R2D)
  );

  // Sign extension through a signed cast to XLEN
  always_comb begin
    case (ImmSrcD)
      immS:    ImmExtD = XLEN'($signed({InstrD[31:25], InstrD[11:7]}));
      immU:    ImmExtD = XLEN'($signed({InstrD[31:12], 12'b0}));
      default: ImmExtD = XLEN'($signed(InstrD[31:20]));   // immI
    endcase
  end

  //////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (FlushE) begin                  // Load-use bubble
      R1E     <= '0;
      R2E     <= '0;
      ImmExtE <= '0;
      Rs1E    <= '0;
      Rs2E    <= '0;
      RdE     <= '0;
    end else if (!StallD) begin
      R1E     <= R1D;
      R2E     <= R2D;
      ImmExtE <= ImmExtD;
      Rs1E    <= Rs1D;
      Rs2E    <= Rs2D;
      RdE     <= RdD;
    end
  end

  assign SrcAE      = fwdMux(ForwardAE, R1E, IeuResultM, ResultW);
  assign WriteDataE = fwdMux(ForwardBE, R2E, IeuResultM, ResultW);
  assign SrcBE      = AluSrcBE ? ImmExtE : WriteDataE;

  alu #(.XLEN(XLEN)) aluUnit (
    .SrcA(SrcAE), .SrcB(SrcBE), .AluOp(AluOpE), .Result(AluResultE)
  );

  assign IeuResultE = LuiE ? ImmExtE : AluResultE;  // lui skips the ALU

  //////////////////////////////////////////////////
  // Memory and Writeback
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    IeuResultM <= IeuResultE;   // Address for lw/sw, else result
    WriteDataM <= WriteDataE;
    RdM        <= RdE;
    IeuResultW <= IeuResultM;
    RdW        <= RdM;
  end

  assign MemAdrM = IeuResultM;
  assign ResultW = (ResultSrcW == resMem) ? ReadDataW : IeuResultW;

endmodule

`default_nettype wire

// ==== control/controller.sv ====
// Instruction decoder and control pipeline from Decode to Writeback, instantiated by intCore
`timescale 1ns/10ps
`default_nettype none

module controller (
  input  logic               clk,
  input  logic               reset,
  input  logic [31:0]        InstrD,
  input  logic               InstrValidD,
  input  logic               StallD,
  input  logic               FlushE,
  output corePkg::immSrcT    ImmSrcD,
  output corePkg::aluOpT     AluOpE,
  output logic               AluSrcBE,
  output logic               LuiE,
  output logic               MemWriteM,
  output logic               MemReadM,
  output logic               RegWriteM,
  output logic               RegWriteW,
  output corePkg::resultSrcT ResultSrcW,
  output logic               MemReadE      // Load in Execute, to hazard unit
);

  import corePkg::*;

  opcodeT    OpD;
  logic [2:0] Funct3D;
  logic      Funct7b5D;        // Picks sub and sra
  logic      LegalD, ValidD;
  aluOpT     AluOpD;
  logic      RegWriteD, MemWriteD, MemReadD, AluSrcBD, LuiD;
  resultSrcT ResultSrcD;
  logic      RegWriteE, MemWriteE;
  resultSrcT ResultSrcE, ResultSrcM;

  assign OpD       = opcodeT'(InstrD[6:0]);
  assign Funct3D   = InstrD[14:12];
  assign Funct7b5D = InstrD[30];

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  always_comb begin
    LegalD     = 1'b1;
    ImmSrcD    = immI;
    AluOpD     = aluAdd;        // Address add for lw/sw
    RegWriteD  = 1'b0;
    MemWriteD  = 1'b0;
    MemReadD   = 1'b0;
    AluSrcBD   = 1'b1;
    LuiD       = 1'b0;
    ResultSrcD = resAlu;
    case (OpD)
      opReg, opImm: begin
        RegWriteD = 1'b1;
        AluSrcBD  = (OpD == opImm);
        case (Funct3D)
          3'b000:  AluOpD = (OpD == opReg && Funct7b5D) ? aluSub : aluAdd;
          3'b001:  AluOpD = aluSll;
          3'b010:  AluOpD = aluSlt;
          3'b011:  AluOpD = aluSltu;
          3'b100:  AluOpD = aluXor;
          3'b101:  AluOpD = Funct7b5D ? aluSra : aluSrl;
          3'b110:  AluOpD = aluOr;
          default: AluOpD = aluAnd;
        endcase
      end
      opLui: begin
        ImmSrcD   = immU;
        RegWriteD = 1'b1;
        LuiD      = 1'b1;
      end
      opLoad: begin
        LegalD     = (Funct3D == 3'b010);   // Word only
        RegWriteD  = 1'b1;
        MemReadD   = 1'b1;
        ResultSrcD = resMem;
      end
      opStore: begin
        LegalD    = (Funct3D == 3'b010);
        ImmSrcD   = immS;
        MemWriteD = 1'b1;
      end
      default: LegalD = 1'b0;
    endcase
  end

  assign ValidD = InstrValidD && LegalD;

  //////////////////////////////////////////////////
  // Control pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || FlushE) begin          // Bubble carries no strobes
      RegWriteE  <= 1'b0;
      MemWriteE  <= 1'b0;
      MemReadE   <= 1'b0;
      AluOpE     <= aluAdd;
      AluSrcBE   <= 1'b0;
      LuiE       <= 1'b0;
      ResultSrcE <= resAlu;
    end else if (!StallD) begin
      RegWriteE  <= ValidD && RegWriteD;
      MemWriteE  <= ValidD && MemWriteD;
      MemReadE   <= ValidD && MemReadD;
      AluOpE     <= AluOpD;
      AluSrcBE   <= AluSrcBD;
      LuiE       <= LuiD;
      ResultSrcE <= ResultSrcD;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      RegWriteM  <= 1'b0;
      MemWriteM  <= 1'b0;
      MemReadM   <= 1'b0;
      ResultSrcM <= resAlu;
      RegWriteW  <= 1'b0;
      ResultSrcW <= resAlu;
    end else begin
      RegWriteM  <= RegWriteE;
      MemWriteM  <= MemWriteE;
      MemReadM   <= MemReadE;
      ResultSrcM <= ResultSrcE;
      RegWriteW  <= RegWriteM;
      ResultSrcW <= ResultSrcM;   // Load data arrives with it
    end
  end

endmodule

`default_nettype wire

// ==== src/hazardUnit.sv ====
// Hazard unit instantiated by intCore for forwarding selects and the load-use stall with its bubble
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
  input  logic [corePkg::RegAddrWidth-1:0] Rs1D,
  input  logic [corePkg::RegAddrWidth-1:0] Rs2D,
  input  logic [corePkg::RegAddrWidth-1:0] Rs1E,
  input  logic [corePkg::RegAddrWidth-1:0] Rs2E,
  input  logic [corePkg::RegAddrWidth-1:0] RdE,
  input  logic [corePkg::RegAddrWidth-1:0] RdM,
  input  logic [corePkg::RegAddrWidth-1:0] RdW,
  input  logic                             RegWriteM,
  input  logic                             RegWriteW,
  input  logic                             MemReadE,
  input  logic                             InstrValidD,
  output logic [1:0]                       ForwardAE,
  output logic [1:0]                       ForwardBE,
  output logic                             StallD,
  output logic                             FlushE
);

  import corePkg::*;

  logic LoadUseD;

  // Youngest producer wins so Memory beats Writeback
  function automatic logic [1:0] fwdSel(input logic [RegAddrWidth-1:0] Rs);
    if (RegWriteM && RdM != '0 && RdM == Rs)
      return 2'b10;
    else if (RegWriteW && RdW != '0 && RdW == Rs)
      return 2'b01;
    else
      return 2'b00;               // Register file value
  endfunction

  always_comb begin
    ForwardAE = fwdSel(Rs1E);     // Operand A source
    ForwardBE = fwdSel(Rs2E);     // Operand B and store data source
  end

  // Load result not ready until Writeback
  assign LoadUseD = InstrValidD && MemReadE && RdE != '0 &&
                    (RdE == Rs1D || RdE == Rs2D);

  assign StallD = LoadUseD;
  assign FlushE = LoadUseD;        // Bubble while Decode holds

endmodule

`default_nettype wire

// ==== src/intCore.sv ====
// Top level of the integer pipeline, joining controller, datapath and hazard unit for the testbench
`timescale 1ns/10ps
`default_nettype none

module intCore #(
  parameter int XLEN = corePkg::DefaultXlen
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [31:0]                      InstrD,
  input  logic                             InstrValidD,
  input  logic [XLEN-1:0]                  ReadDataW,    // One cycle after MemReadM
  output logic                             StallD,       // Source holds InstrD
  output logic [XLEN-1:0]                  MemAdrM,
  output logic [XLEN-1:0]                  WriteDataM,
  output logic                             MemWriteM,
  output logic                             MemReadM,
  output logic                             RegWriteW,
  output logic [corePkg::RegAddrWidth-1:0] RdW,
  output logic [XLEN-1:0]                  ResultW
);

  import corePkg::*;

  immSrcT                  ImmSrcD;
  aluOpT                   AluOpE;
  logic                    AluSrcBE, LuiE;
  logic                    RegWriteM, MemReadE;
  resultSrcT               ResultSrcW;
  logic [1:0]              ForwardAE, ForwardBE;
  logic                    FlushE;
  logic [RegAddrWidth-1:0] Rs1D, Rs2D, Rs1E, Rs2E, RdE, RdM;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  controller ctrl (
    .clk(clk), .reset(reset), .InstrD(InstrD), .InstrValidD(InstrValidD),
    .StallD(StallD), .FlushE(FlushE), .ImmSrcD(ImmSrcD),
    .AluOpE(AluOpE), .AluSrcBE(AluSrcBE), .LuiE(LuiE),
    .MemWriteM(MemWriteM), .MemReadM(MemReadM), .RegWriteM(RegWriteM),
    .RegWriteW(RegWriteW), .ResultSrcW(ResultSrcW), .MemReadE(MemReadE)
  );

  datapath #(.XLEN(XLEN)) dp (
    .clk(clk), .reset(reset), .InstrD(InstrD), .StallD(StallD), .FlushE(FlushE),
    .ImmSrcD(ImmSrcD), .AluOpE(AluOpE), .AluSrcBE(AluSrcBE), .LuiE(LuiE),
    .ForwardAE(ForwardAE), .ForwardBE(ForwardBE),
    .RegWriteW(RegWriteW), .ResultSrcW(ResultSrcW), .ReadDataW(ReadDataW),
    .Rs1D(Rs1D), .Rs2D(Rs2D), .Rs1E(Rs1E), .Rs2E(Rs2E),
    .RdE(RdE), .RdM(RdM), .RdW(RdW),
    .MemAdrM(MemAdrM), .WriteDataM(WriteDataM), .ResultW(ResultW)
  );

  hazardUnit hu (
    .Rs1D(Rs1D), .Rs2D(Rs2D), .Rs1E(Rs1E), .Rs2E(Rs2E),
    .RdE(RdE), .RdM(RdM), .RdW(RdW),
    .RegWriteM(RegWriteM), .RegWriteW(RegWriteW),
    .MemReadE(MemReadE), .InstrValidD(InstrValidD),
    .ForwardAE(ForwardAE), .ForwardBE(ForwardBE),
    .StallD(StallD), .FlushE(FlushE)
  );

endmodule

`default_nettype wire

// ==== dv/intCoreTb.sv ====
// Top-level directed testbench run by run.sh that drives intCore as instruction source and memory
`timescale 1ns/10ps
`default_nettype none

module intCoreTb;

  localparam int XLEN = 32;
  localparam logic [6:0] OpcReg   = 7'b0110011;  // RV32I major opcodes
  localparam logic [6:0] OpcImm   = 7'b0010011;
  localparam logic [6:0] OpcLui   = 7'b0110111;
  localparam logic [6:0] OpcLoad  = 7'b0000011;
  localparam logic [6:0] OpcStore = 7'b0100011;

  logic            clk = 1'b0;
  logic            reset;
  logic [31:0]     InstrD;
  logic            InstrValidD;
  logic [XLEN-1:0] ReadDataW;
  logic            StallD;
  logic [XLEN-1:0] MemAdrM;
  logic [XLEN-1:0] WriteDataM;
  logic            MemWriteM;
  logic            MemReadM;
  logic            RegWriteW;
  logic [4:0]      RdW;
  logic [XLEN-1:0] ResultW;

  logic [31:0] refRegs [32];             // In-order architectural state
  logic [31:0] refMem [logic [31:0]];    // Reference view of memory
  logic [31:0] dataMem [logic [31:0]];   // Memory seen by the DUT
  logic [4:0]  expRd [$];
  logic [31:0] expVal [$];
  logic [31:0] expStAdr [$];
  logic [31:0] expStData [$];
  logic [31:0] expLdAdr [$];
  logic [31:0] randState = 32'hacce_fdd8;
  int          cycleCount = 0;
  int          issuedCount = 0;
  logic        stallSeen;
  logic [4:0]  prevLoadRd;               // Load now heading into Execute
  logic        readPending;              // Load seen in Memory last cycle
  logic [31:0] readAdr;

  always #4 clk = ~clk;                  // 8 ns period

  intCore #(.XLEN(XLEN)) i_dut (
    .clk(clk), .reset(reset), .InstrD(InstrD), .InstrValidD(InstrValidD),
    .ReadDataW(ReadDataW), .StallD(StallD), .MemAdrM(MemAdrM), .WriteDataM(WriteDataM),
    .MemWriteM(MemWriteM), .MemReadM(MemReadM), .RegWriteW(RegWriteW), .RdW(RdW),
    .ResultW(ResultW)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] nextRand();
    logic [31:0] x;
    x = randState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    randState = x;
    return x;
  endfunction

  // Fill for unwritten words that depends on every address bit
  function automatic logic [31:0] fillWord(input logic [31:0] adr);
    return ~adr ^ {adr[7:0], adr[31:8]};
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OpcReg};
  endfunction

  function automatic logic [31:0] encI(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encS(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpcStore};   // sw only
  endfunction

  function automatic logic [31:0] encU(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OpcLui};
  endfunction

  // RV32I semantics by funct3 where alt picks sub or sra
  function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? ((a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0))
                          : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else failRun($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp));
  endtask

  // Model the instruction in order and then hand it to Decode while honouring StallD
  task automatic issueInstr(input logic [31:0] instr);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] adr;
    logic [31:0] res;
    logic        expStall;
    int          stalls;
    rd   = instr[11:7];
    a    = refRegs[instr[19:15]];
    b    = refRegs[instr[24:20]];
    immI = {{20{instr[31]}}, instr[31:20]};
    res  = '0;
    // Load right ahead whose rd matches either source field
    expStall = prevLoadRd != 5'd0 &&
               (prevLoadRd == instr[19:15] || prevLoadRd == instr[24:20]);
    prevLoadRd = (instr[6:0] == OpcLoad) ? rd : 5'd0;
    case (instr[6:0])
      OpcReg:  res = refAlu(instr[14:12], instr[30], a, b);
      OpcImm:  res = refAlu(instr[14:12], instr[14:12] == 3'd5 && instr[30], a, immI);
      OpcLui:  res = {instr[31:12], 12'b0};
      OpcLoad: begin
        adr = a + immI;
        res = refMem.exists(adr) ? refMem[adr] : fillWord(adr);
        expLdAdr.push_back(adr);
      end
      default: begin                      // sw
        adr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
        refMem[adr] = b;
        expStAdr.push_back(adr);
        expStData.push_back(b);
      end
    endcase
    if (instr[6:0] != OpcStore) begin
      expRd.push_back(rd);                // x0 writes still leave the pipe
      expVal.push_back(res);
      if (rd != 5'd0) refRegs[rd] = res;
    end
    issuedCount++;
    stalls = 0;
    @(negedge clk);
    InstrD      = instr;
    InstrValidD = 1'b1;
    @(posedge clk);
    while (StallD) begin                  // Held and not taken this edge
      stallSeen = 1'b1;
      stalls++;
      @(posedge clk);
    end
    checkEq("StallD cycles", 32'(stalls), {31'b0, expStall});
  endtask

  task automatic idleCycles(input int n);
    prevLoadRd = 5'd0;
    repeat (n) begin
      @(negedge clk);
      InstrValidD = 1'b0;
      InstrD      = '0;
    end
  endtask

  // lui plus addi with the upper part rounded for a negative low half
  task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] t;
    t = v + 32'h800;
    issueInstr(encU(rd, t[31:12]));
    issueInstr(encI(OpcImm, 3'd0, rd, rd, v[11:0]));
  endtask

  //////////////////////////////////////////////////
  // Monitors and memory model
  //////////////////////////////////////////////////

  task automatic checkRegWrite();
    logic [4:0]  eRd;
    logic [31:0] eVal;
    assert (expRd.size() > 0)
    else failRun("A register write came out with no instruction expecting it");
    eRd  = expRd.pop_front();
    eVal = expVal.pop_front();
    checkEq("RdW", {27'b0, RdW}, {27'b0, eRd});
    checkEq("ResultW", ResultW, eVal);
  endtask

  task automatic checkStore();
    logic [31:0] eAdr;
    logic [31:0] eData;
    assert (expStAdr.size() > 0) else failRun("A store came out with no sw expecting it");
    eAdr  = expStAdr.pop_front();
    eData = expStData.pop_front();
    checkEq("MemAdrM", MemAdrM, eAdr);
    checkEq("WriteDataM", WriteDataM, eData);
    dataMem[MemAdrM] = WriteDataM;
  endtask

  task automatic checkLoad();
    logic [31:0] eAdr;
    assert (expLdAdr.size() > 0) else failRun("A load came out with no lw expecting it");
    eAdr = expLdAdr.pop_front();
    checkEq("MemAdrM", MemAdrM, eAdr);
  endtask

  // Outputs sampled at the edge before the DUT registers update
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > 4 * issuedCount + 200) failRun("Timeout, the pipeline stopped retiring");
    if (!reset && RegWriteW) checkRegWrite();
  end

  always @(negedge clk) begin
    ReadDataW = '0;
    if (readPending) begin                // Load now in Writeback
      ReadDataW = dataMem.exists(readAdr) ? dataMem[readAdr] : fillWord(readAdr);
    end
    readPending = !reset && MemReadM === 1'b1;
    readAdr     = MemAdrM;
    if (readPending) checkLoad();
    if (!reset && MemWriteM === 1'b1) checkStore();
  end

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic testResetState();
    @(negedge clk);
    checkEq("StallD", {31'b0, StallD}, '0);
    checkEq("MemWriteM", {31'b0, MemWriteM}, '0);
    checkEq("MemReadM", {31'b0, MemReadM}, '0);
    checkEq("RegWriteW", {31'b0, RegWriteW}, '0);
    for (int r = 1; r < 32; r++) issueInstr(encI(OpcImm, 3'd0, r[4:0], r[4:0], 12'd0));
  endtask

  task automatic testAluOps();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    for (int it = 0; it < 4; it++) begin
      a = nextRand();
      b = nextRand();
      if (it < 2) a[31] = 1'b1;           // Negative rs1 for sra and slt
      if (it == 1) b[31] = 1'b0;          // Signs differ so slt and sltu disagree
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      for (int f3 = 0; f3 < 8; f3++) begin
        issueInstr(encR(7'd0, f3[2:0], 5'd3, 5'd1, 5'd2));
        imm = 12'(nextRand());
        if (f3 == 1 || f3 == 5) imm[11:5] = 7'd0;   // Shift amount only
        issueInstr(encI(OpcImm, f3[2:0], 5'd4, 5'd1, imm));
      end
      issueInstr(encR(7'b0100000, 3'd0, 5'd5, 5'd1, 5'd2));            // sub
      issueInstr(encR(7'b0100000, 3'd5, 5'd6, 5'd1, 5'd2));            // sra
      issueInstr(encI(OpcImm, 3'd5, 5'd7, 5'd1, {7'b0100000, b[4:0]})); // srai
    end
  endtask

  task automatic testLui();
    issueInstr(encU(5'd10, 20'habcde));
    loadConst(5'd11, 32'hdead_beef);
    loadConst(5'd12, 32'h1234_5fff);      // Low half rounds the upper part up
    loadConst(5'd13, nextRand());
    issueInstr(encR(7'd0, 3'd0, 5'd14, 5'd11, 5'd12));
  endtask

  task automatic testForwarding();
    for (int d = 1; d <= 3; d++) begin
      issueInstr(encI(OpcImm, 3'd0, 5'd20, 5'd20, 12'(nextRand())));  // Producer
      for (int f = 1; f < d; f++) issueInstr(encI(OpcImm, 3'd4, 5'd21, 5'd22, 12'h055));
      issueInstr(encR(7'd0, 3'd0, 5'd23, 5'd20, 5'd20));               // Distance d
      issueInstr(encR(7'b0100000, 3'd0, 5'd24, 5'd23, 5'd20));         // Memory and older
    end
  endtask

  task automatic testLoadUse();
    stallSeen = 1'b0;
    loadConst(5'd5, 32'h0000_1000 + (nextRand() & 32'h0000_0ff0));
    issueInstr(encI(OpcLoad, 3'd2, 5'd6, 5'd5, 12'd0));
    issueInstr(encR(7'd0, 3'd0, 5'd7, 5'd6, 5'd6));       // Uses the load at once
    issueInstr(encI(OpcLoad, 3'd2, 5'd8, 5'd5, 12'd4));
    issueInstr(encI(OpcImm, 3'd0, 5'd9, 5'd8, 12'd1));
    issueInstr(encI(OpcLoad, 3'd2, 5'd10, 5'd5, 12'hffc));
    issueInstr(encR(7'd0, 3'd7, 5'd11, 5'd2, 5'd10));     // Load result on rs2
    assert (stallSeen) else failRun("StallD never rose during the load-use test");
  endtask

  task automatic testStoreLoad();
    loadConst(5'd15, 32'h0000_2000 + (nextRand() & 32'h0000_0ff0));
    loadConst(5'd16, nextRand());
    issueInstr(encS(5'd16, 5'd15, 12'd8));               // Store data forwarded
    issueInstr(encS(5'd1, 5'd15, 12'hff8));              // Negative offset
    issueInstr(encI(OpcLoad, 3'd2, 5'd17, 5'd15, 12'd8));
    issueInstr(encI(OpcLoad, 3'd2, 5'd18, 5'd15, 12'hff8));
    issueInstr(encR(7'd0, 3'd4, 5'd19, 5'd17, 5'd18));
  endtask

  task automatic testX0Writes();
    issueInstr(encI(OpcImm, 3'd0, 5'd0, 5'd0, 12'h07b));  // Strobe still issued
    issueInstr(encR(7'd0, 3'd0, 5'd25, 5'd0, 5'd0));      // x0 never forwarded
    issueInstr(encU(5'd0, 20'hfffff));
    issueInstr(encI(OpcImm, 3'd6, 5'd26, 5'd0, 12'd0));
    issueInstr(encI(OpcImm, 3'd0, 5'd0, 5'd1, 12'h001));
    idleCycles(3);
    issueInstr(encR(7'd0, 3'd6, 5'd27, 5'd0, 5'd0));      // Register file x0
  endtask

  initial begin
    int waited;
    reset       = 1'b1;
    InstrD      = '0;
    InstrValidD = 1'b0;
    ReadDataW   = '0;
    readPending = 1'b0;
    readAdr     = '0;
    stallSeen   = 1'b0;
    prevLoadRd  = 5'd0;
    for (int i = 0; i < 32; i++) refRegs[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    testResetState();
    testAluOps();
    testLui();
    testForwarding();
    testLoadUse();
    testStoreLoad();
    testX0Writes();
    idleCycles(1);
    waited = 0;
    while ((expRd.size() != 0 || expStAdr.size() != 0 || expLdAdr.size() != 0) &&
           waited < 16) begin
      @(posedge clk);
      waited++;
    end
    if (expRd.size() == 0 && expStAdr.size() == 0 && expLdAdr.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      failRun("Expected register or memory writes never came out of the pipeline");
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
common/corePkg.sv
datapath/regFile.sv
datapath/alu.sv
datapath/datapath.sv
control/controller.sv
src/hazardUnit.sv
src/intCore.sv
dv/intCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the intCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module intCoreTb --Mdir obj_dir -o intCoreTbSim

./obj_dir/intCoreTbSim | tee sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
grep -q "TB PASSED" sim.log
